// File: common/apu_params.svh
`ifndef APU_PARAMS_SVH
`define APU_PARAMS_SVH

// noise channel register indices
`define NR41_ADDR 2'd0
`define NR42_ADDR 2'd1
`define NR43_ADDR 2'd2
`define NR44_ADDR 2'd3

// bits that always read back as one
`define NR41_RD_MASK 8'hff
`define NR42_RD_MASK 8'h00
`define NR43_RD_MASK 8'h00
`define NR44_RD_MASK 8'hbf

`define NOISE_LFSR_W 15 // full-width noise shift register
`define FRAME_STEPS 8 // steps per frame sequence

`endif

// File: common/apu_reg_pkg.sv
`default_nettype none

package apu_reg_pkg;

	// cpu side of the sound unit register file
	typedef logic [1:0] reg_addr_t; // register index within the channel
	typedef logic [7:0] reg_data_t; // one register byte

endpackage

`default_nettype wire

// File: common/noise_pkg.sv
`default_nettype none

`include "apu_params.svh"

package noise_pkg;

	typedef logic [3:0] volume_t; // volume and output sample
	typedef logic [2:0] env_period_t; // envelope step period
	typedef logic [6:0] length_t; // length count, 0 to 64
	typedef logic [`NOISE_LFSR_W-1:0] lfsr_t;
	typedef logic [3:0] shift_t; // timer clock shift
	typedef logic [2:0] div_code_t; // timer divisor code

	typedef enum logic [1:0] {
		ENV_IDLE,
		ENV_RUN,
		ENV_DONE
	} env_state_t;

endpackage

`default_nettype wire

// File: noise/noise_envelope.sv
`timescale 1ns/10ps
`default_nettype none

module noise_envelope (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   trigger,
	input  logic                   env_tick,
	input  noise_pkg::volume_t     init_volume,
	input  logic                   env_up,
	input  noise_pkg::env_period_t env_period,
	output noise_pkg::volume_t     volume
);

	noise_pkg::env_state_t  state;
	noise_pkg::env_period_t period_q; // captured at trigger
	noise_pkg::env_period_t period_cnt;
	logic                   up_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= noise_pkg::ENV_IDLE;
			volume     <= '0;
			period_q   <= '0;
			period_cnt <= '0;
			up_q       <= 1'b0;
		end else if (trigger) begin
			volume     <= init_volume;
			period_q   <= env_period;
			period_cnt <= env_period;
			up_q       <= env_up;
			if (env_period == '0)
				state <= noise_pkg::ENV_IDLE; // period 0 holds the volume
			else
				state <= noise_pkg::ENV_RUN;
		end else if (env_tick && state == noise_pkg::ENV_RUN) begin
			if (period_cnt == 3'd1) begin
				period_cnt <= period_q;
				if (up_q) begin
					if (volume == 4'hf)
						state <= noise_pkg::ENV_DONE;
					else
						volume <= volume + 4'd1;
				end else begin
					if (volume == 4'h0)
						state <= noise_pkg::ENV_DONE;
					else
						volume <= volume - 4'd1;
				end
			end else begin
				period_cnt <= period_cnt - 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: noise/noise_length.sv
`timescale 1ns/10ps
`default_nettype none

module noise_length (
	input  logic       clk,
	input  logic       rst,
	input  logic       length_load,
	input  logic [5:0] length_data,
	input  logic       length_en,
	input  logic       length_tick,
	input  logic       trigger,
	output logic       length_expired
);

	localparam noise_pkg::length_t FULL_LENGTH = 7'd64;

	noise_pkg::length_t count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count          <= '0;
			length_expired <= 1'b0;
		end else begin
			length_expired <= 1'b0;
			if (length_load) begin
				count <= FULL_LENGTH - {1'b0, length_data};
			end else if (trigger) begin
				if (count == '0)
					count <= FULL_LENGTH; // only reload when run out
			end else if (length_tick && length_en && count != '0) begin
				count          <= count - 7'd1;
				length_expired <= (count == 7'd1);
			end
		end
	end

endmodule

`default_nettype wire

// File: noise/noise_lfsr.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_params.svh"

module noise_lfsr (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 trigger,
	input  noise_pkg::shift_t    shift,
	input  logic                 width7,
	input  noise_pkg::div_code_t div_code,
	output logic                 noise_bit
);

	localparam int TIMER_W = 20; // 112 << 13 fits

	logic [6:0]         divisor;
	logic [TIMER_W-1:0] period;
	logic [TIMER_W-1:0] timer;
	logic               stopped;
	logic               feedback;
	noise_pkg::lfsr_t   lfsr;
	noise_pkg::lfsr_t   lfsr_next;

	assign divisor = (div_code == '0) ? 7'd8 : {div_code, 4'b0000};
	assign period  = {{(TIMER_W-7){1'b0}}, divisor} << shift;
	assign stopped = (shift >= 4'd14); // shifts 14 and 15 freeze the clock

	assign feedback = lfsr[0] ^ lfsr[1];

	always_comb begin
		lfsr_next = {feedback, lfsr[`NOISE_LFSR_W-1:1]};
		if (width7)
			lfsr_next[6] = feedback; // short 7-bit loop
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			timer <= '0;
			lfsr  <= '0;
		end else if (trigger) begin
			timer <= period;
			lfsr  <= '1;
		end else if (!stopped && timer != '0) begin
			if (timer == TIMER_W'(1)) begin
				timer <= period;
				lfsr  <= lfsr_next;
			end else begin
				timer <= timer - TIMER_W'(1);
			end
		end
	end

	assign noise_bit = ~lfsr[0];

endmodule

`default_nettype wire

// File: noise/noise_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_params.svh"

module noise_regs (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    reg_wr,
	input  apu_reg_pkg::reg_addr_t  reg_addr,
	input  apu_reg_pkg::reg_data_t  reg_wr_data,
	output apu_reg_pkg::reg_data_t  reg_rd_data,
	output logic                    length_load,
	output logic [5:0]              length_data,
	output noise_pkg::volume_t      init_volume,
	output logic                    env_up,
	output noise_pkg::env_period_t  env_period,
	output logic                    dac_en,
	output noise_pkg::shift_t       shift,
	output logic                    width7,
	output noise_pkg::div_code_t    div_code,
	output logic                    length_en,
	output logic                    trigger
);

	apu_reg_pkg::reg_data_t nr41, nr42, nr43, nr44;

	logic wr_nr41, wr_nr44;

	assign wr_nr41 = reg_wr && (reg_addr == apu_reg_pkg::reg_addr_t'(`NR41_ADDR));
	assign wr_nr44 = reg_wr && (reg_addr == apu_reg_pkg::reg_addr_t'(`NR44_ADDR));

	always_ff @(posedge clk) begin
		if (rst) begin
			nr41        <= '0;
			nr42        <= '0;
			nr43        <= '0;
			nr44        <= '0;
			length_load <= 1'b0;
			trigger     <= 1'b0;
		end else begin
			if (reg_wr) begin
				case (reg_addr)
					apu_reg_pkg::reg_addr_t'(`NR41_ADDR): nr41 <= reg_wr_data;
					apu_reg_pkg::reg_addr_t'(`NR42_ADDR): nr42 <= reg_wr_data;
					apu_reg_pkg::reg_addr_t'(`NR43_ADDR): nr43 <= reg_wr_data;
					default:                              nr44 <= reg_wr_data;
				endcase
			end
			length_load <= wr_nr41;
			trigger     <= wr_nr44 && reg_wr_data[7] && dac_en; // no restart with dac off
		end
	end

	always_comb begin
		case (reg_addr)
			apu_reg_pkg::reg_addr_t'(`NR41_ADDR): reg_rd_data = nr41 | `NR41_RD_MASK;
			apu_reg_pkg::reg_addr_t'(`NR42_ADDR): reg_rd_data = nr42 | `NR42_RD_MASK;
			apu_reg_pkg::reg_addr_t'(`NR43_ADDR): reg_rd_data = nr43 | `NR43_RD_MASK;
			default:                              reg_rd_data = nr44 | `NR44_RD_MASK;
		endcase
	end

	assign length_data = nr41[5:0];
	assign init_volume = nr42[7:4];
	assign env_up      = nr42[3];
	assign env_period  = nr42[2:0];
	assign dac_en      = |nr42[7:3]; // any volume or upward envelope
	assign shift       = nr43[7:4];
	assign width7      = nr43[3];
	assign div_code    = nr43[2:0];
	assign length_en   = nr44[6];

endmodule

`default_nettype wire

// File: rtl/frame_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_params.svh"

module frame_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic frame_tick, // 512 Hz strobe
	output logic length_tick,
	output logic env_tick
);

	localparam logic [2:0] LAST_STEP = 3'(`FRAME_STEPS - 1);

	logic [2:0] step;

	always_ff @(posedge clk) begin
		if (rst) begin
			step        <= '0;
			length_tick <= 1'b0;
			env_tick    <= 1'b0;
		end else begin
			length_tick <= frame_tick && !step[0]; // steps 0, 2, 4, 6
			env_tick    <= frame_tick && (step == LAST_STEP);
			if (frame_tick) begin
				if (step == LAST_STEP)
					step <= '0;
				else
					step <= step + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/noise_channel.sv
`timescale 1ns/10ps
`default_nettype none

module noise_channel (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   frame_tick,
	input  logic                   reg_wr,
	input  apu_reg_pkg::reg_addr_t reg_addr,
	input  apu_reg_pkg::reg_data_t reg_wr_data,
	output apu_reg_pkg::reg_data_t reg_rd_data,
	output noise_pkg::volume_t     ch_out,
	output logic                   ch_active,
	output logic                   dac_en
);

	logic                   length_tick, env_tick;
	logic                   length_load, length_en, length_expired;
	logic [5:0]             length_data;
	noise_pkg::volume_t     init_volume, volume;
	logic                   env_up;
	noise_pkg::env_period_t env_period;
	noise_pkg::shift_t      shift;
	noise_pkg::div_code_t   div_code;
	logic                   width7, trigger, noise_bit;

	frame_sequencer frame_sequencer_i (
		.clk(clk), .rst(rst), .frame_tick(frame_tick),
		.length_tick(length_tick), .env_tick(env_tick)
	);

	noise_regs noise_regs_i (
		.clk(clk), .rst(rst), .reg_wr(reg_wr), .reg_addr(reg_addr),
		.reg_wr_data(reg_wr_data), .reg_rd_data(reg_rd_data),
		.length_load(length_load), .length_data(length_data),
		.init_volume(init_volume), .env_up(env_up), .env_period(env_period),
		.dac_en(dac_en), .shift(shift), .width7(width7), .div_code(div_code),
		.length_en(length_en), .trigger(trigger)
	);

	noise_length noise_length_i (
		.clk(clk), .rst(rst), .length_load(length_load), .length_data(length_data),
		.length_en(length_en), .length_tick(length_tick), .trigger(trigger),
		.length_expired(length_expired)
	);

	noise_envelope noise_envelope_i (
		.clk(clk), .rst(rst), .trigger(trigger), .env_tick(env_tick),
		.init_volume(init_volume), .env_up(env_up), .env_period(env_period),
		.volume(volume)
	);

	noise_lfsr noise_lfsr_i (
		.clk(clk), .rst(rst), .trigger(trigger), .shift(shift),
		.width7(width7), .div_code(div_code), .noise_bit(noise_bit)
	);

	always_ff @(posedge clk) begin
		if (rst)
			ch_active <= 1'b0;
		else if (!dac_en)
			ch_active <= 1'b0; // dac off kills the channel
		else if (trigger)
			ch_active <= 1'b1;
		else if (length_expired)
			ch_active <= 1'b0;
	end

	assign ch_out = (ch_active && noise_bit) ? volume : '0;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the noise channel testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module noise_tb \
	-Mdir obj_dir -o noise_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/noise_tb_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
	exit 0
fi
exit 1

// File: sim.f
+incdir+common
common/apu_reg_pkg.sv
common/noise_pkg.sv
rtl/frame_sequencer.sv
noise/noise_regs.sv
noise/noise_length.sv
noise/noise_envelope.sv
noise/noise_lfsr.sv
rtl/noise_channel.sv
verification/tb_clock_gen.sv
verification/noise_assert.sv
verification/noise_tb.sv

// File: verification/noise_assert.sv
`timescale 1ns/10ps
`default_nettype none

module noise_assert (
	input logic               clk,
	input logic               rst,
	input noise_pkg::volume_t ch_out,
	input logic               ch_active,
	input logic               dac_en,
	input logic               trigger
);

	int fail_count = 0;

	out_needs_active: assert property (@(posedge clk) disable iff (rst)
		(ch_out != '0) |-> ch_active)
		else begin
			fail_count++;
			$error("ch_out is non-zero while the channel is inactive");
		end

	// ch_active is registered, so it follows dac_en one cycle late
	active_needs_dac: assert property (@(posedge clk) disable iff (rst)
		!dac_en |=> !ch_active)
		else begin
			fail_count++;
			$error("channel stayed active after the DAC was switched off");
		end

	single_trigger: assert property (@(posedge clk) disable iff (rst)
		trigger |=> !trigger)
		else begin
			fail_count++;
			$error("trigger stayed high for two cycles");
		end

endmodule

bind noise_channel noise_assert noise_assert_i (
	.clk(clk), .rst(rst), .ch_out(ch_out), .ch_active(ch_active),
	.dac_en(dac_en), .trigger(trigger)
);

`default_nettype wire

// File: verification/noise_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "apu_params.svh"

module noise_tb;

	localparam int FRAME_CYCLES = 64;
	localparam int MAX_FRAMES = 16 + 136 + 112; // length test and both envelope sweeps
	localparam int TIMEOUT_CYCLES = 2 * (MAX_FRAMES * FRAME_CYCLES + 2 * 400 + 500);

	logic                   clk, rst, frame_tick, reg_wr;
	apu_reg_pkg::reg_addr_t reg_addr;
	apu_reg_pkg::reg_data_t reg_wr_data, reg_rd_data;
	noise_pkg::volume_t     ch_out;
	logic                   ch_active, dac_en;

	int          cycle_count = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          frame_step = 0;
	int          last_step = 0;
	logic [31:0] rng_state = 32'h9e5adfe4;

	tb_clock_gen tb_clock_gen_i (.clk(clk), .rst(rst));

	noise_channel noise_channel_i (
		.clk(clk), .rst(rst), .frame_tick(frame_tick), .reg_wr(reg_wr),
		.reg_addr(reg_addr), .reg_wr_data(reg_wr_data), .reg_rd_data(reg_rd_data),
		.ch_out(ch_out), .ch_active(ch_active), .dac_en(dac_en)
	);

	function automatic apu_reg_pkg::reg_data_t rand_byte();
		apu_reg_pkg::reg_data_t b;
		for (int i = 0; i < 8; i++) begin
			b[i] = rng_state[0];
			rng_state = rng_state[0] ? ((rng_state >> 1) ^ 32'h80200003) : (rng_state >> 1);
		end
		return b;
	endfunction

	function automatic noise_pkg::lfsr_t lfsr_step(input noise_pkg::lfsr_t s, input logic w7);
		logic             fb;
		noise_pkg::lfsr_t n;
		fb = s[0] ^ s[1];
		n = {fb, s[14:1]};
		if (w7)
			n[6] = fb;
		return n;
	endfunction

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed", test_errors);
		test_errors = 0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic write_reg(input apu_reg_pkg::reg_addr_t addr, input apu_reg_pkg::reg_data_t data);
		@(negedge clk);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wr_data = data;
		@(negedge clk);
		reg_wr = 1'b0;
	endtask

	task automatic read_check(input apu_reg_pkg::reg_addr_t addr, input apu_reg_pkg::reg_data_t exp);
		@(negedge clk);
		reg_addr = addr;
		#1;
		check_value($sformatf("reg_rd_data[%0d]", addr), int'(reg_rd_data), int'(exp));
	endtask

	// one frame strobe, then the rest of the 64 cycles while tracking the peak sample
	task automatic run_frame(output noise_pkg::volume_t max_out);
		@(negedge clk);
		frame_tick = 1'b1;
		last_step = frame_step;
		frame_step = (frame_step + 1) % `FRAME_STEPS;
		@(negedge clk);
		frame_tick = 1'b0;
		max_out = '0;
		repeat (FRAME_CYCLES - 2) begin
			@(negedge clk);
			if (ch_out > max_out)
				max_out = ch_out;
		end
	endtask

	task automatic reset_state();
		check_value("ch_active", int'(ch_active), 0);
		check_value("dac_en", int'(dac_en), 0);
		check_value("ch_out", int'(ch_out), 0);
		read_check(`NR41_ADDR, `NR41_RD_MASK);
		read_check(`NR42_ADDR, `NR42_RD_MASK);
		read_check(`NR43_ADDR, `NR43_RD_MASK);
		read_check(`NR44_ADDR, `NR44_RD_MASK);
		end_test("reset state");
	endtask

	task automatic reg_readback();
		apu_reg_pkg::reg_data_t val [4];
		for (int i = 0; i < 4; i++) begin
			val[i] = rand_byte();
			if (i == 3)
				val[i][7] = 1'b0; // keep the channel from starting
			write_reg(2'(i), val[i]);
		end
		read_check(`NR41_ADDR, val[0] | `NR41_RD_MASK);
		read_check(`NR42_ADDR, val[1] | `NR42_RD_MASK);
		read_check(`NR43_ADDR, val[2] | `NR43_RD_MASK);
		read_check(`NR44_ADDR, val[3] | `NR44_RD_MASK);
		end_test("register read-back");
	endtask

	task automatic dac_gating();
		write_reg(`NR42_ADDR, 8'h00);
		check_value("dac_en", int'(dac_en), 0);
		write_reg(`NR44_ADDR, 8'h80);
		wait_cycles(2);
		check_value("ch_active", int'(ch_active), 0);
		check_value("ch_out", int'(ch_out), 0);
		write_reg(`NR42_ADDR, 8'hf0);
		check_value("dac_en", int'(dac_en), 1);
		write_reg(`NR44_ADDR, 8'h80);
		wait_cycles(2);
		check_value("ch_active", int'(ch_active), 1);
		write_reg(`NR42_ADDR, 8'h00);
		wait_cycles(1);
		check_value("ch_active", int'(ch_active), 0);
		check_value("ch_out", int'(ch_out), 0);
		end_test("dac gating");
	endtask

	task automatic length_expiry();
		int                 remaining;
		noise_pkg::volume_t max_out;
		write_reg(`NR42_ADDR, 8'hf0);
		write_reg(`NR41_ADDR, 8'd60);
		write_reg(`NR44_ADDR, 8'h80);
		remaining = 64 - 60;
		repeat (4) begin
			run_frame(max_out);
			check_value("ch_active", int'(ch_active), 1);
		end
		write_reg(`NR44_ADDR, 8'h40); // length on, no restart
		for (int f = 0; f < 12 && remaining != 0; f++) begin
			run_frame(max_out);
			if (last_step % 2 == 0)
				remaining--;
			check_value("ch_active", int'(ch_active), int'(remaining != 0));
		end
		end_test("length expiry");
	endtask

	task automatic noise_sequence(input logic w7);
		noise_pkg::lfsr_t model;
		write_reg(`NR42_ADDR, 8'hf0); // volume 15, envelope held
		write_reg(`NR43_ADDR, {4'h0, w7, 3'd0});
		write_reg(`NR44_ADDR, 8'h80);
		wait_cycles(1); // first look right after the trigger edge
		model = '1;
		for (int k = 0; k < 400; k++) begin
			if (k > 0 && k % 8 == 0)
				model = lfsr_step(model, w7);
			check_value("ch_out", int'(ch_out), model[0] ? 0 : 15);
			wait_cycles(1);
		end
		end_test(w7 ? "noise 7-bit" : "noise 15-bit");
	endtask

	task automatic envelope_sweep(input noise_pkg::volume_t init_vol, input logic up,
			input int n_ticks, input string name);
		noise_pkg::volume_t model_vol, max_out;
		int                 ticks;
		int                 frames;
		ticks = 0;
		frames = 0;
		write_reg(`NR42_ADDR, {init_vol, up, 3'd1});
		write_reg(`NR43_ADDR, 8'h08); // fast 7-bit noise keeps the peak visible
		write_reg(`NR44_ADDR, 8'h80);
		model_vol = init_vol;
		while (ticks < n_ticks && frames < 8 * n_ticks + 8) begin
			run_frame(max_out);
			frames++;
			if (last_step == `FRAME_STEPS - 1) begin
				ticks++;
				if (up && model_vol != 4'hf)
					model_vol++; // period 1 steps on every tick
				else if (!up && model_vol != 4'h0)
					model_vol--;
				check_value("peak ch_out", int'(max_out), int'(model_vol));
			end
		end
		end_test(name);
	endtask

	initial begin
		frame_tick = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wr_data = '0;
		@(negedge rst);
		@(negedge clk);
		reset_state();
		reg_readback();
		dac_gating();
		length_expiry();
		noise_sequence(1'b0);
		noise_sequence(1'b1);
		envelope_sweep(4'hf, 1'b0, 16, "envelope down");
		envelope_sweep(4'h3, 1'b1, 13, "envelope up");
		$display("tests run %0d, failed %0d, assertion failures %0d",
			tests_run, tests_failed, noise_channel_i.noise_assert_i.fail_count);
		if (tests_failed == 0 && noise_channel_i.noise_assert_i.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	localparam time HALF_PERIOD = 5ns; // 10 ns clock
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire
